// ==== fifo_flopped_2w2r.f ====
fifo_2w2r_pkg.sv
fifo_flopped.sv
lane_steer.sv
fifo_flopped_2w2r.sv
tb_fifo_flopped_2w2r.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the two-write two-read queue testbench with Verilator

TOP=tb_fifo_flopped_2w2r
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -f fifo_flopped_2w2r.f --top-module "$TOP" \
  && ./obj_dir/V"$TOP" > "$LOG" 2>&1 \
  || { echo "Build or simulation run failed"; exit 1; }

cat "$LOG"

# The result line in the log decides the outcome
grep -q "TEST RESULT: PASS" "$LOG" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

// ==== tb_fifo_flopped_2w2r.sv ====
`timescale 1ns/100ps

// Testbench for the two-write two-read queue, checked against a queue model
module tb_fifo_flopped_2w2r
  import fifo_2w2r_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 5;
  localparam int DIRECTED_CYCLES = 64;
  localparam int RAND_CYCLES     = 2000;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES;
  localparam int TIMEOUT_NS      = TOTAL_CYCLES * CLK_PERIOD + 100;

  logic              clk;
  logic              rst_n;
  logic              push0;
  logic              push1;
  logic              pop0;
  logic              pop1;
  logic [DWIDTH-1:0] in_data0;
  logic [DWIDTH-1:0] in_data1;
  logic [DWIDTH-1:0] out_data0;
  logic [DWIDTH-1:0] out_data1;
  logic              fifo_half_full;
  logic              fifo_full;
  logic              fifo_1left_to_full;
  logic              fifo_empty;
  logic              fifo_1left_to_empty;
  logic              fifo_idle;

  // Reference model, front is the oldest entry
  logic [DWIDTH-1:0] model_q[$];

  int errors;
  int checks;

  fifo_flopped_2w2r dut_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .push0               (push0),
    .inData0             (in_data0),
    .push1               (push1),
    .inData1             (in_data1),
    .pop0                (pop0),
    .outData0            (out_data0),
    .pop1                (pop1),
    .outData1            (out_data1),
    .fifo_halfFull       (fifo_half_full),
    .fifo_full           (fifo_full),
    .fifo_1left_to_full  (fifo_1left_to_full),
    .fifo_empty          (fifo_empty),
    .fifo_1left_to_empty (fifo_1left_to_empty),
    .fifo_idle           (fifo_idle)
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic drive_idle();
    push0    = 1'b0;
    push1    = 1'b0;
    pop0     = 1'b0;
    pop1     = 1'b0;
    in_data0 = '0;
    in_data1 = '0;
  endtask

  task automatic check_value(input string name, input logic [DWIDTH-1:0] got,
                             input logic [DWIDTH-1:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, expected);
    end
  endtask

  // Whole queue flags from the stored count alone
  task automatic check_flags(input int n, input bit active);
    check_flag("fifo_full", fifo_full, n == DEPTH);
    check_flag("fifo_1left_to_full", fifo_1left_to_full, n == DEPTH - 1);
    check_flag("fifo_halfFull", fifo_half_full, n >= DEPTH / 2);
    check_flag("fifo_empty", fifo_empty, n == 0);
    check_flag("fifo_1left_to_empty", fifo_1left_to_empty, n == 1);
    check_flag("fifo_idle", fifo_idle, (n == 0) && !active);
  endtask

  // One clock cycle with the given numbers of pushes and pops, lane 0 first
  task automatic run_cycle(input int n_push, input int n_pop);
    int                n;
    logic [DWIDTH-1:0] d0;
    logic [DWIDTH-1:0] d1;
    n  = model_q.size();
    d0 = $urandom;
    d1 = $urandom;
    @(posedge clk);
    #1;
    push0    = (n_push >= 1);
    push1    = (n_push == 2);
    pop0     = (n_pop >= 1);
    pop1     = (n_pop == 2);
    in_data0 = d0;
    in_data1 = d1;
    // Outputs have settled by the falling edge
    @(negedge clk);
    check_flags(n, (n_push + n_pop) > 0);
    // Show-ahead heads, which are also what this cycle's pops take
    if (n >= 1) begin
      check_value("outData0", out_data0, model_q[0]);
    end
    if (n >= 2) begin
      check_value("outData1", out_data1, model_q[1]);
    end
    // Model follows the coming edge
    if (n_pop >= 1) begin
      void'(model_q.pop_front());
    end
    if (n_pop == 2) begin
      void'(model_q.pop_front());
    end
    if (n_push >= 1) begin
      model_q.push_back(d0);
    end
    if (n_push == 2) begin
      model_q.push_back(d1);
    end
  endtask

  // Legal random traffic, limited by free space and stored entries
  task automatic run_random(input int cycles);
    int n_push;
    int n_pop;
    int space;
    repeat (cycles) begin
      space  = DEPTH - model_q.size();
      n_push = $urandom_range(2, 0);
      n_pop  = $urandom_range(2, 0);
      n_push = (n_push > space) ? space : n_push;
      n_pop  = (n_pop > model_q.size()) ? model_q.size() : n_pop;
      run_cycle(n_push, n_pop);
    end
  endtask

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h559f));
    errors = 0;
    checks = 0;
    rst_n  = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Quiet cycle right after reset
    run_cycle(0, 0);

    // Dual pushes to full, then dual pops to empty
    repeat (DEPTH / 2) run_cycle(2, 0);
    repeat (DEPTH / 2) run_cycle(0, 2);

    // Single entries flip both swap flags every cycle
    repeat (DEPTH) run_cycle(1, 0);
    repeat (DEPTH) run_cycle(0, 1);

    // Up to seven entries, then push and pop together
    repeat (3) run_cycle(2, 0);
    run_cycle(1, 0);
    repeat (4) run_cycle(1, 1);

    // Down to one entry, two pushes with one pop
    repeat (3) run_cycle(0, 2);
    run_cycle(2, 1);
    run_cycle(0, 1);
    run_cycle(2, 1);
    run_cycle(0, 2);

    run_random(RAND_CYCLES);
    run_cycle(0, 0);

    $display("Errors: %0d, values checked: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== fifo_flopped_2w2r.sv ====
`timescale 1ns/100ps

// Two-write two-read queue built from an even and an odd bank
module fifo_flopped_2w2r
  import fifo_2w2r_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  // Write lanes
  input  logic              push0,
  input  logic [DWIDTH-1:0] inData0,
  input  logic              push1,
  input  logic [DWIDTH-1:0] inData1,
  // Read lanes
  input  logic              pop0,
  output logic [DWIDTH-1:0] outData0,
  input  logic              pop1,
  output logic [DWIDTH-1:0] outData1,
  // Whole queue status
  output logic              fifo_halfFull,
  output logic              fifo_full,
  output logic              fifo_1left_to_full,
  output logic              fifo_empty,
  output logic              fifo_1left_to_empty,
  output logic              fifo_idle
);

  // Lane side pairs
  strobe_pair_t push_pair;
  strobe_pair_t pop_pair;
  data_pair_t   in_pair;
  data_pair_t   out_pair;

  // Bank side pairs, lane0 is the even bank
  strobe_pair_t bank_push;
  strobe_pair_t bank_pop;
  data_pair_t   bank_in;
  data_pair_t   bank_head;

  // Per bank status
  bank_status_t even_status;
  bank_status_t odd_status;

  // Pack the external lanes
  assign push_pair.lane0 = push0;
  assign push_pair.lane1 = push1;
  assign pop_pair.lane0  = pop0;
  assign pop_pair.lane1  = pop1;
  assign in_pair.lane0   = inData0;
  assign in_pair.lane1   = inData1;

  // Push side steering
  lane_steer push_steer (
    .clk      (clk),
    .rst_n    (rst_n),
    .lane_req (push_pair),
    .bank_req (bank_push),
    .data_in  (in_pair),
    .data_out (bank_in)
  );

  // Pop side steering
  // Head data goes in at the bank side and comes out on the lanes
  lane_steer pop_steer (
    .clk      (clk),
    .rst_n    (rst_n),
    .lane_req (pop_pair),
    .bank_req (bank_pop),
    .data_in  (bank_head),
    .data_out (out_pair)
  );

  // Entries 0, 2, 4, ...
  fifo_flopped fifo_even (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (bank_push.lane0),
    .in_data  (bank_in.lane0),
    .pop      (bank_pop.lane0),
    .out_data (bank_head.lane0),
    .status   (even_status)
  );

  // Entries 1, 3, 5, ...
  fifo_flopped fifo_odd (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (bank_push.lane1),
    .in_data  (bank_in.lane1),
    .pop      (bank_pop.lane1),
    .out_data (bank_head.lane1),
    .status   (odd_status)
  );

  // Oldest entry on lane 0
  assign outData0 = out_pair.lane0;
  assign outData1 = out_pair.lane1;

  // Status merge
  // Banks never differ by more than one entry
  assign fifo_full     = even_status.full && odd_status.full;
  assign fifo_halfFull = even_status.half_full && odd_status.half_full;
  assign fifo_empty    = even_status.empty && odd_status.empty;
  assign fifo_idle     = even_status.idle && odd_status.idle;

  // One bank full and the other one short
  assign fifo_1left_to_full  = even_status.full ^ odd_status.full;

  // One entry left in a single bank
  assign fifo_1left_to_empty = even_status.empty ^ odd_status.empty;

endmodule

// ==== lane_steer.sv ====
`timescale 1ns/100ps

// Lane crossbar with a swap flag that tracks bank parity
module lane_steer
  import fifo_2w2r_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  strobe_pair_t lane_req,
  output strobe_pair_t bank_req,
  input  data_pair_t   data_in,
  output data_pair_t   data_out
);

  // Set when the next entry belongs to the odd bank
  logic swap;
  logic swap_nxt;

  logic any_req;
  logic single_req;

  // Lane 0 alone moves the next entry to the other bank
  assign single_req = lane_req.lane0 && !lane_req.lane1;
  assign any_req    = lane_req.lane0 || lane_req.lane1;

  // Dual strobes keep the parity
  assign swap_nxt = single_req ? !swap : swap;

  // Flag only moves on cycles with activity
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      swap <= 1'b0;
    end else if (any_req) begin
      swap <= swap_nxt;
    end
  end

  // Strobe crossbar
  always_comb begin
    if (swap) begin
      bank_req.lane0 = lane_req.lane1;
      bank_req.lane1 = lane_req.lane0;
    end else begin
      bank_req.lane0 = lane_req.lane0;
      bank_req.lane1 = lane_req.lane1;
    end
  end

  // Data crossbar
  // Same crossing both ways, so it also serves the pop side head data
  always_comb begin
    if (swap) begin
      data_out.lane0 = data_in.lane1;
      data_out.lane1 = data_in.lane0;
    end else begin
      data_out.lane0 = data_in.lane0;
      data_out.lane1 = data_in.lane1;
    end
  end

endmodule

// ==== fifo_flopped.sv ====
`timescale 1ns/100ps

// Single-lane flopped queue with show-ahead head entry
module fifo_flopped
  import fifo_2w2r_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  logic [DWIDTH-1:0] in_data,
  input  logic              pop,
  output logic [DWIDTH-1:0] out_data,
  output bank_status_t      status
);

  // Storage
  logic [DWIDTH-1:0] mem [DEPTH_SUB];

  // Pointers and occupancy
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Qualified strobes
  logic push_ok;
  logic pop_ok;

  // Decoded occupancy
  logic is_full;
  logic is_empty;
  logic is_half;

  assign is_full  = (count == CNT_W'(DEPTH_SUB));
  assign is_empty = (count == '0);
  assign is_half  = (count >= CNT_W'(DEPTH_SUB / 2));

  // Push into a full bank or pop from an empty one is dropped
  assign push_ok = push && !is_full;
  assign pop_ok  = pop && !is_empty;

  // Entry write, no reset on the payload
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Write pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (push_ok) begin
      // Depth is a power of two so the pointer wraps by itself
      wr_ptr <= wr_ptr + PTR_W'(1);
    end
  end

  // Read pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (pop_ok) begin
      rd_ptr <= rd_ptr + PTR_W'(1);
    end
  end

  // Occupancy count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10: begin
          count <= count + CNT_W'(1);
        end
        2'b01: begin
          count <= count - CNT_W'(1);
        end
        default: begin
          // Push with pop, or nothing at all
          count <= count;
        end
      endcase
    end
  end

  // Show-ahead head, so a pop takes what is shown this cycle
  assign out_data = mem[rd_ptr];

  // Status flags from the registered count
  always_comb begin
    status.full      = is_full;
    status.empty     = is_empty;
    status.half_full = is_half;
    // Idle also looks at the live strobes
    status.idle      = is_empty && !push && !pop;
  end

endmodule

// ==== fifo_2w2r_pkg.sv ====
package fifo_2w2r_pkg;

  // Width of one queue entry
  localparam int DWIDTH = 32;

  // Capacity of the whole queue, split evenly over two banks
  localparam int DEPTH     = 8;
  localparam int DEPTH_SUB = DEPTH / 2;

  // Bank pointer and occupancy widths
  localparam int PTR_W = $clog2(DEPTH_SUB);
  localparam int CNT_W = PTR_W + 1;

  // One strobe per lane
  typedef struct packed {
    logic lane1;
    logic lane0;
  } strobe_pair_t;

  // One entry per lane
  typedef struct packed {
    logic [DWIDTH-1:0] lane1;
    logic [DWIDTH-1:0] lane0;
  } data_pair_t;

  // Status of a single bank
  typedef struct packed {
    logic full;
    logic empty;
    logic half_full;
    // Empty and no strobe this cycle
    logic idle;
  } bank_status_t;

endpackage
